// ==== verification/exe_golden.txt ====
# name op pc_src pc op1_src op2_src imm rs1_src rs2_src ex_rs1 ex_rs2 me_alu wb_rd
# then expected new_rs1 new_rs2 alu_result b_flag target_pc, all values in hex
fwd_ex 01 0 1000 0 0 0 0 0 11 22 33 44 11 22 33 0 1000
fwd_mem 01 0 1000 0 0 0 1 2 11 22 33 44 33 44 77 0 1000
fwd_wb 01 0 1000 0 0 0 2 1 11 22 33 44 44 33 77 0 1000
add_ovf 01 0 1000 0 0 0 0 0 7fffffffffffffff 1 0 0 7fffffffffffffff 1 8000000000000000 0 1000
addi 01 0 1000 0 1 10 0 0 5 7 0 0 5 7 15 0 1010
sub 0a 0 1000 0 0 0 0 0 5 7 0 0 5 7 fffffffffffffffe 0 1000
slt 02 0 1000 0 0 0 0 0 ffffffffffffffff 1 0 0 ffffffffffffffff 1 1 0 1000
sltu 03 0 1000 0 0 0 0 0 ffffffffffffffff 1 0 0 ffffffffffffffff 1 0 0 1000
xor 04 0 1000 0 0 0 0 0 f0f0 ff00 0 0 f0f0 ff00 ff0 0 1000
or 05 0 1000 0 0 0 0 0 f0f0 ff00 0 0 f0f0 ff00 fff0 0 1000
and 06 0 1000 0 0 0 0 0 f0f0 ff00 0 0 f0f0 ff00 f000 0 1000
sll 07 0 1000 0 0 0 0 0 1 3f 0 0 1 3f 8000000000000000 0 1000
srl 08 0 1000 0 0 0 0 0 8000000000000000 4 0 0 8000000000000000 4 0800000000000000 0 1000
sra 09 0 1000 0 0 0 0 0 8000000000000000 4 0 0 8000000000000000 4 f800000000000000 0 1000
addw 12 0 1000 0 0 0 0 0 7fffffff 1 0 0 7fffffff 1 ffffffff80000000 0 1000
subw 13 0 1000 0 0 0 0 0 100000000 1 0 0 100000000 1 ffffffffffffffff 0 1000
sllw 14 0 1000 0 0 0 0 0 1 1f 0 0 1 1f ffffffff80000000 0 1000
srlw 15 0 1000 0 0 0 0 0 ffffffff80000000 4 0 0 ffffffff80000000 4 8000000 0 1000
sraw 16 0 1000 0 0 0 0 0 80000000 4 0 0 80000000 4 fffffffff8000000 0 1000
lui 0b 0 1000 0 1 12345000 0 0 0 0 0 0 0 0 12345000 0 12346000
csr 1e 0 1000 0 0 0 0 0 abc 0 0 0 abc 0 abc 0 1000
jal 01 0 1000 1 2 100 0 0 0 0 0 0 0 0 1004 0 1100
jalr 01 1 1000 1 2 10 0 0 2001 0 0 0 2001 0 1004 0 2010
beq_t 0c 0 1000 0 0 80 0 0 5 5 0 0 5 5 0 1 1080
beq_f 0c 0 1000 0 0 80 0 0 5 6 0 0 5 6 0 0 1080
bne_t 0d 0 1000 0 0 80 0 0 5 6 0 0 5 6 0 1 1080
bne_f 0d 0 1000 0 0 80 0 0 5 5 0 0 5 5 0 0 1080
blt_t 0e 0 1000 0 0 80 0 0 ffffffffffffffff 1 0 0 ffffffffffffffff 1 0 1 1080
blt_f 0e 0 1000 0 0 80 0 0 1 ffffffffffffffff 0 0 1 ffffffffffffffff 0 0 1080
blt_ovf 0e 0 1000 0 0 80 0 0 8000000000000000 1 0 0 8000000000000000 1 0 1 1080
bge_t 0f 0 1000 0 0 80 0 0 1 ffffffffffffffff 0 0 1 ffffffffffffffff 0 1 1080
bge_f 0f 0 1000 0 0 80 0 0 ffffffffffffffff 1 0 0 ffffffffffffffff 1 0 0 1080
bltu_t 10 0 1000 0 0 80 0 0 1 ffffffffffffffff 0 0 1 ffffffffffffffff 0 1 1080
bltu_f 10 0 1000 0 0 80 0 0 ffffffffffffffff 1 0 0 ffffffffffffffff 1 0 0 1080
bgeu_t 11 0 1000 0 0 80 0 0 ffffffffffffffff 1 0 0 ffffffffffffffff 1 0 1 1080
bgeu_f 11 0 1000 0 0 80 0 0 1 ffffffffffffffff 0 0 1 ffffffffffffffff 0 0 1080
mul 17 0 1000 0 0 0 0 0 fffffffffffffffd 7 0 0 fffffffffffffffd 7 ffffffffffffffeb 0 1000
mulh 18 0 1000 0 0 0 0 0 fffffffffffffffe 8000000000000000 0 0 fffffffffffffffe 8000000000000000 1 0 1000
mulh_neg 18 0 1000 0 0 0 0 0 8000000000000000 3 0 0 8000000000000000 3 fffffffffffffffe 0 1000
mulw 19 0 1000 0 0 0 0 0 100040000 2000 0 0 100040000 2000 ffffffff80000000 0 1000
div 1a 0 1000 0 0 0 0 0 fffffffffffffff9 2 0 0 fffffffffffffff9 2 fffffffffffffffd 0 1000
rem 1b 0 1000 0 0 0 0 0 fffffffffffffff9 2 0 0 fffffffffffffff9 2 ffffffffffffffff 0 1000
divw 1c 0 1000 0 0 0 0 0 ffffffff00000064 fffffff9 0 0 ffffffff00000064 fffffff9 fffffffffffffff2 0 1000
remw 1d 0 1000 0 0 0 0 0 ffffff9c 7 0 0 ffffff9c 7 fffffffffffffffe 0 1000
div_zero 1a 0 1000 0 0 0 0 0 1234 0 0 0 1234 0 ffffffffffffffff 0 1000
rem_zero 1b 0 1000 0 0 0 0 0 1234 0 0 0 1234 0 1234 0 1000
divw_zero 1c 0 1000 0 0 0 0 0 5 100000000 0 0 5 100000000 ffffffffffffffff 0 1000
div_ovf 1a 0 1000 0 0 0 0 0 8000000000000000 ffffffffffffffff 0 0 8000000000000000 ffffffffffffffff 8000000000000000 0 1000
remw_ovf 1d 0 1000 0 0 0 0 0 80000000 ffffffff 0 0 80000000 ffffffff 0 0 1000

// ==== exe_stage.f ====
logic/exe_pkg.sv
logic/operand_bus_if.sv
logic/operand_select.sv
logic/adder64.sv
logic/alu_core.sv
logic/divider64.sv
logic/exe_stage.sv
verification/exe_stage_tb.sv

// ==== Bender.yml ====
package:
  name: exe_stage

sources:
  - files:
      - logic/exe_pkg.sv
      - logic/operand_bus_if.sv
      - logic/operand_select.sv
      - logic/adder64.sv
      - logic/alu_core.sv
      - logic/divider64.sv
      - logic/exe_stage.sv
  - target: test
    files:
      - verification/exe_stage_tb.sv

// ==== verification/exe_stage_tb.sv ====
`timescale 1ns/1ns

module exe_stage_tb;

	localparam int w = exe_pkg::xlen;

	typedef struct packed {
		logic [127:0] name;
		logic [4:0]   op;
		logic         pc_src;
		logic [w-1:0] pc;
		logic         op1_src;
		logic [1:0]   op2_src;
		logic [w-1:0] imm;
		logic [1:0]   rs1_src;
		logic [1:0]   rs2_src;
		logic [w-1:0] ex_rs1;
		logic [w-1:0] ex_rs2;
		logic [w-1:0] me_alu;
		logic [w-1:0] wb_rd;
		logic [w-1:0] exp_rs1;
		logic [w-1:0] exp_rs2;
		logic [w-1:0] exp_alu;
		logic         exp_b;
		logic [w-1:0] exp_tgt;
	} vector_t;

	logic clk = 1'b0;
	logic rst_n;
	logic [exe_pkg::alu_op_w-1:0] alu_op;
	logic pc_src, alu_op1_src;
	logic [1:0] alu_op2_src, rs1_src, rs2_src;
	logic [w-1:0] pc, imm, ex_rs1_data, ex_rs2_data, me_alu_result, wb_rd_data;
	logic stall_req, b_flag;
	logic [w-1:0] new_rs1_data, new_rs2_data, alu_result, target_pc;

	vector_t vectors[$];
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 1000;
	logic load_ok;
	logic [31:0] rng = 32'hcd76_f7b9;

	exe_stage dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.alu_op        (alu_op),
		.pc_src        (pc_src),
		.pc            (pc),
		.alu_op1_src   (alu_op1_src),
		.alu_op2_src   (alu_op2_src),
		.imm           (imm),
		.rs1_src       (rs1_src),
		.rs2_src       (rs2_src),
		.ex_rs1_data   (ex_rs1_data),
		.ex_rs2_data   (ex_rs2_data),
		.me_alu_result (me_alu_result),
		.wb_rd_data    (wb_rd_data),
		.stall_req     (stall_req),
		.new_rs1_data  (new_rs1_data),
		.new_rs2_data  (new_rs2_data),
		.alu_result    (alu_result),
		.target_pc     (target_pc),
		.b_flag        (b_flag)
	);

	always #5 clk = ~clk;  // 10 ns period.

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic compare_value(input logic [127:0] name, input string what,
			input logic [w-1:0] expected, input logic [w-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error: %0s %0s expected %h actual %h", name, what, expected, actual);
		end
	endtask

	task automatic load_vectors(output logic ok);
		int fd;
		int n;
		int r;
		logic [8*320-1:0] line;
		logic [127:0] name;
		logic [w-1:0] f [0:16];
		vector_t v;
		fd = $fopen("verification/exe_golden.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = '0;
				name = '0;
				r = $fgets(line, fd);
				n = (r == 0) ? 0 : $sscanf(line,
					"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
				if (n == 18) begin
					v.name    = name;
					v.op      = f[0][4:0];
					v.pc_src  = f[1][0];
					v.pc      = f[2];
					v.op1_src = f[3][0];
					v.op2_src = f[4][1:0];
					v.imm     = f[5];
					v.rs1_src = f[6][1:0];
					v.rs2_src = f[7][1:0];
					v.ex_rs1  = f[8];
					v.ex_rs2  = f[9];
					v.me_alu  = f[10];
					v.wb_rd   = f[11];
					v.exp_rs1 = f[12];
					v.exp_rs2 = f[13];
					v.exp_alu = f[14];
					v.exp_b   = f[15][0];
					v.exp_tgt = f[16];
					vectors.push_back(v);
				end else if (n > 0 && name != "#") begin
					errors++;
					$display("a line of the golden file after vector %0d could not be read",
						vectors.size());
				end
			end
			$fclose(fd);
			ok = (vectors.size() > 0);
		end
	endtask

	task automatic idle_cycles(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			alu_op <= '0;  // no operation.
			@(negedge clk);
			compare_value("idle", "alu_result", '0, alu_result);
			compare_value("idle", "stall_req", '0, stall_req);
		end
	endtask

	task automatic run_vector(input vector_t v);
		logic is_div;
		is_div = (v.op == exe_pkg::alu_div) || (v.op == exe_pkg::alu_rem)
		      || (v.op == exe_pkg::alu_divw) || (v.op == exe_pkg::alu_remw);
		@(posedge clk);
		alu_op        <= v.op;
		pc_src        <= v.pc_src;
		pc            <= v.pc;
		alu_op1_src   <= v.op1_src;
		alu_op2_src   <= v.op2_src;
		imm           <= v.imm;
		rs1_src       <= v.rs1_src;
		rs2_src       <= v.rs2_src;
		ex_rs1_data   <= v.ex_rs1;
		ex_rs2_data   <= v.ex_rs2;
		me_alu_result <= v.me_alu;
		wb_rd_data    <= v.wb_rd;
		@(negedge clk);
		compare_value(v.name, "stall_req in first cycle", is_div, stall_req);
		while (stall_req) begin
			@(negedge clk);  // divider still busy.
		end
		compare_value(v.name, "new_rs1_data", v.exp_rs1, new_rs1_data);
		compare_value(v.name, "new_rs2_data", v.exp_rs2, new_rs2_data);
		compare_value(v.name, "alu_result", v.exp_alu, alu_result);
		compare_value(v.name, "b_flag", v.exp_b, b_flag);
		compare_value(v.name, "target_pc", v.exp_tgt, target_pc);
	endtask

	initial begin
		rst_n         = 1'b0;
		alu_op        = '0;
		pc_src        = 1'b0;
		pc            = '0;
		alu_op1_src   = 1'b0;
		alu_op2_src   = '0;
		imm           = '0;
		rs1_src       = '0;
		rs2_src       = '0;
		ex_rs1_data   = '0;
		ex_rs2_data   = '0;
		me_alu_result = '0;
		wb_rd_data    = '0;
		load_vectors(load_ok);
		if (!load_ok) begin
			$display("the golden vector file is missing or holds no vectors");
		end else begin
			cycle_limit = vectors.size() * 70 + 50;  // a divide needs under 70 cycles.
			repeat (2) @(posedge clk);
			rst_n <= 1'b1;
			idle_cycles(1);  // idle right after reset.
			foreach (vectors[i]) begin
				run_vector(vectors[i]);
				rng = xorshift32(rng);
				idle_cycles(rng % 4);
			end
		end
		$display("checked %0d vectors with %0d errors", vectors.size(), errors);
		if (load_ok && errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== logic/exe_stage.sv ====
`timescale 1ns/1ns

module exe_stage (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [exe_pkg::alu_op_w-1:0] alu_op,
	input  logic                         pc_src,
	input  logic [exe_pkg::xlen-1:0]     pc,
	input  logic                         alu_op1_src,
	input  logic [1:0]                   alu_op2_src,
	input  logic [exe_pkg::xlen-1:0]     imm,
	input  logic [1:0]                   rs1_src,
	input  logic [1:0]                   rs2_src,
	input  logic [exe_pkg::xlen-1:0]     ex_rs1_data,
	input  logic [exe_pkg::xlen-1:0]     ex_rs2_data,
	input  logic [exe_pkg::xlen-1:0]     me_alu_result,
	input  logic [exe_pkg::xlen-1:0]     wb_rd_data,
	output logic                         stall_req,
	output logic [exe_pkg::xlen-1:0]     new_rs1_data,
	output logic [exe_pkg::xlen-1:0]     new_rs2_data,
	output logic [exe_pkg::xlen-1:0]     alu_result,
	output logic [exe_pkg::xlen-1:0]     target_pc,
	output logic                         b_flag
);

	logic                 div_valid;
	logic                 div_32;
	logic                 div_ready;
	exe_pkg::div_result_t div_result;

	operand_bus_if ops_bus ();

	operand_select u_sel (
		.ex_rs1_data   (ex_rs1_data),
		.ex_rs2_data   (ex_rs2_data),
		.me_alu_result (me_alu_result),
		.wb_rd_data    (wb_rd_data),
		.pc            (pc),
		.imm           (imm),
		.rs1_src       (rs1_src),
		.rs2_src       (rs2_src),
		.alu_op1_src   (alu_op1_src),
		.alu_op2_src   (alu_op2_src),
		.ops           (ops_bus.source)
	);

	alu_core u_alu (
		.alu_op     (alu_op),
		.pc_src     (pc_src),
		.pc         (pc),
		.imm        (imm),
		.ops        (ops_bus.sink),
		.div_result (div_result),
		.div_ready  (div_ready),
		.div_valid  (div_valid),
		.div_32     (div_32),
		.stall_req  (stall_req),
		.alu_result (alu_result),
		.target_pc  (target_pc),
		.b_flag     (b_flag)
	);

	divider64 u_div (
		.clk        (clk),
		.rst_n      (rst_n),
		.div_valid  (div_valid),
		.div_32     (div_32),
		.ops        (ops_bus.sink),
		.div_result (div_result),
		.div_ready  (div_ready)
	);

	assign new_rs1_data = ops_bus.rs1_val;  // forwarded values go on to the mem stage.
	assign new_rs2_data = ops_bus.rs2_val;

endmodule

// ==== logic/divider64.sv ====
`timescale 1ns/1ns

module divider64 (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 div_valid,
	input  logic                 div_32,
	operand_bus_if.sink          ops,
	output exe_pkg::div_result_t div_result,
	output logic                 div_ready
);

	localparam int w = exe_pkg::xlen;

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_busy = 2'd1;
	localparam logic [1:0] st_sign = 2'd2;  // apply signs, write result.
	localparam logic [1:0] st_done = 2'd3;  // ready pulse.

	logic [1:0] state;
	logic [5:0] cnt;
	logic [w-1:0] dvd_ext, dvs_ext, dvd_mag, dvs_mag, most_neg;
	logic [w-1:0] rem_r, quo_r, dvs_r, dvd_r;
	logic w32_r, neg_q_r, neg_r_r, by_zero_r, ovf_r;
	logic [w:0] trial;
	logic [w-1:0] q_fix, r_fix;
	exe_pkg::div_result_t res_next;

	// word operands are sign-extended so both widths share one path.
	assign dvd_ext  = div_32 ? {{32{ops.rs1_val[31]}}, ops.rs1_val[31:0]} : ops.rs1_val;
	assign dvs_ext  = div_32 ? {{32{ops.rs2_val[31]}}, ops.rs2_val[31:0]} : ops.rs2_val;
	assign dvd_mag  = dvd_ext[w-1] ? -dvd_ext : dvd_ext;
	assign dvs_mag  = dvs_ext[w-1] ? -dvs_ext : dvs_ext;
	assign most_neg = div_32 ? {{33{1'b1}}, 31'b0} : {1'b1, {(w-1){1'b0}}};

	// one restoring step.
	assign trial = {rem_r, quo_r[w-1]} - {1'b0, dvs_r};

	// a word quotient ends in quo_r[31:0] with zeros shifted in above.
	assign q_fix = by_zero_r ? '1 : (ovf_r ? dvd_r : (neg_q_r ? -quo_r : quo_r));
	assign r_fix = by_zero_r ? dvd_r : (ovf_r ? '0 : (neg_r_r ? -rem_r : rem_r));

	always_comb begin
		res_next = '0;
		if (w32_r) begin
			res_next.word.quo     = q_fix[31:0];
			res_next.word.quo_pad = {32{q_fix[31]}};
			res_next.word.rem     = r_fix[31:0];
			res_next.word.rem_pad = {32{r_fix[31]}};
		end else begin
			res_next.full.quo = q_fix;
			res_next.full.rem = r_fix;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			cnt        <= '0;
			div_result <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (div_valid) begin
						state <= st_busy;
						cnt   <= div_32 ? 6'd31 : 6'd63;
					end
				end
				st_busy: begin
					if (cnt == '0) begin
						state <= st_sign;
					end else begin
						cnt <= cnt - 6'd1;
					end
				end
				st_sign: begin
					state      <= st_done;
					div_result <= res_next;
				end
				default: state <= st_idle;  // skip the held request once.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && div_valid) begin
			w32_r     <= div_32;
			dvd_r     <= dvd_ext;
			dvs_r     <= dvs_mag;
			rem_r     <= '0;
			quo_r     <= div_32 ? {dvd_mag[31:0], 32'b0} : dvd_mag;  // msb first.
			neg_q_r   <= dvd_ext[w-1] ^ dvs_ext[w-1];
			neg_r_r   <= dvd_ext[w-1];
			by_zero_r <= (dvs_ext == '0);
			ovf_r     <= (dvd_ext == most_neg) && (dvs_ext == '1);
		end else if (state == st_busy) begin
			rem_r <= trial[w] ? {rem_r[w-2:0], quo_r[w-1]} : trial[w-1:0];
			quo_r <= {quo_r[w-2:0], ~trial[w]};
		end
	end

	assign div_ready = (state == st_done);

endmodule

// ==== logic/alu_core.sv ====
`timescale 1ns/1ns

module alu_core (
	input  logic [exe_pkg::alu_op_w-1:0] alu_op,
	input  logic                         pc_src,
	input  logic [exe_pkg::xlen-1:0]     pc,
	input  logic [exe_pkg::xlen-1:0]     imm,
	operand_bus_if.sink                  ops,
	input  exe_pkg::div_result_t         div_result,
	input  logic                         div_ready,
	output logic                         div_valid,
	output logic                         div_32,
	output logic                         stall_req,
	output logic [exe_pkg::xlen-1:0]     alu_result,
	output logic [exe_pkg::xlen-1:0]     target_pc,
	output logic                         b_flag
);

	localparam int w = exe_pkg::xlen;

	logic [31:0] op_hot;
	logic is_add, is_sub, is_slt, is_sltu, is_lui, is_csr;
	logic is_xor, is_or, is_and, is_sll, is_srl, is_sra;
	logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
	logic is_addw, is_subw, is_sllw, is_srlw, is_sraw;
	logic is_mul, is_mulh, is_mulw, is_div, is_rem, is_divw, is_remw;
	logic sub_like;
	logic [w-1:0] op2_add;
	logic [w-1:0] sum;
	logic ovf, sgn, cry, zro;
	logic lt_signed;
	logic [w-1:0] sll_res, srl_res, sra_res;
	logic [31:0] sllw_res, srlw_res, sraw_res;
	logic signed [2*w-1:0] mul_full;
	logic [w-1:0] pc_base;
	logic [w-1:0] tgt_sum;

	function automatic logic [63:0] sext32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	assign op_hot  = 32'd1 << alu_op;  // codes 0 and 31 select nothing.
	assign is_add  = op_hot[exe_pkg::alu_add];
	assign is_slt  = op_hot[exe_pkg::alu_slt];
	assign is_sltu = op_hot[exe_pkg::alu_sltu];
	assign is_xor  = op_hot[exe_pkg::alu_xor];
	assign is_or   = op_hot[exe_pkg::alu_or];
	assign is_and  = op_hot[exe_pkg::alu_and];
	assign is_sll  = op_hot[exe_pkg::alu_sll];
	assign is_srl  = op_hot[exe_pkg::alu_srl];
	assign is_sra  = op_hot[exe_pkg::alu_sra];
	assign is_sub  = op_hot[exe_pkg::alu_sub];
	assign is_lui  = op_hot[exe_pkg::alu_lui];
	assign is_beq  = op_hot[exe_pkg::alu_beq];
	assign is_bne  = op_hot[exe_pkg::alu_bne];
	assign is_blt  = op_hot[exe_pkg::alu_blt];
	assign is_bge  = op_hot[exe_pkg::alu_bge];
	assign is_bltu = op_hot[exe_pkg::alu_bltu];
	assign is_bgeu = op_hot[exe_pkg::alu_bgeu];
	assign is_addw = op_hot[exe_pkg::alu_addw];
	assign is_subw = op_hot[exe_pkg::alu_subw];
	assign is_sllw = op_hot[exe_pkg::alu_sllw];
	assign is_srlw = op_hot[exe_pkg::alu_srlw];
	assign is_sraw = op_hot[exe_pkg::alu_sraw];
	assign is_mul  = op_hot[exe_pkg::alu_mul];
	assign is_mulh = op_hot[exe_pkg::alu_mulh];
	assign is_mulw = op_hot[exe_pkg::alu_mulw];
	assign is_div  = op_hot[exe_pkg::alu_div];
	assign is_rem  = op_hot[exe_pkg::alu_rem];
	assign is_divw = op_hot[exe_pkg::alu_divw];
	assign is_remw = op_hot[exe_pkg::alu_remw];
	assign is_csr  = op_hot[exe_pkg::alu_csr];

	assign div_valid = is_div | is_rem | is_divw | is_remw;  // held while op is present.
	assign div_32    = is_divw | is_remw;
	assign stall_req = div_valid & ~div_ready;

	// subtract and all compares run as op1 + ~op2 + 1.
	assign sub_like = is_sub | is_subw | is_slt | is_sltu | is_beq | is_bne
	                | is_blt | is_bge | is_bltu | is_bgeu;
	assign op2_add  = sub_like ? ~ops.op2 : ops.op2;

	adder64 u_alu_add (
		.op1      (ops.op1),
		.op2      (op2_add),
		.cin      (sub_like),
		.result   (sum),
		.overflow (ovf),
		.sign     (sgn),
		.cout     (),
		.carry    (cry),
		.zero     (zro)
	);

	assign lt_signed = sgn ^ ovf;

	assign sll_res  = ops.op1 << ops.op2[5:0];
	assign srl_res  = ops.op1 >> ops.op2[5:0];
	assign sra_res  = $signed(ops.op1) >>> ops.op2[5:0];
	assign sllw_res = ops.op1[31:0] << ops.op2[4:0];
	assign srlw_res = ops.op1[31:0] >> ops.op2[4:0];
	assign sraw_res = $signed(ops.op1[31:0]) >>> ops.op2[4:0];

	// low word of the full product is the mulw product too.
	assign mul_full = $signed(ops.op1) * $signed(ops.op2);

	assign alu_result = ({w{is_add | is_sub}}   & sum)
	                  | ({w{is_addw | is_subw}} & sext32(sum[31:0]))
	                  | ({w{is_slt}}            & {{(w-1){1'b0}}, lt_signed})
	                  | ({w{is_sltu}}           & {{(w-1){1'b0}}, cry})
	                  | ({w{is_xor}}            & (ops.op1 ^ ops.op2))
	                  | ({w{is_or}}             & (ops.op1 | ops.op2))
	                  | ({w{is_and}}            & (ops.op1 & ops.op2))
	                  | ({w{is_sll}}            & sll_res)
	                  | ({w{is_srl}}            & srl_res)
	                  | ({w{is_sra}}            & sra_res)
	                  | ({w{is_sllw}}           & sext32(sllw_res))
	                  | ({w{is_srlw}}           & sext32(srlw_res))
	                  | ({w{is_sraw}}           & sext32(sraw_res))
	                  | ({w{is_lui}}            & ops.op2)
	                  | ({w{is_csr}}            & ops.op1)
	                  | ({w{is_mul}}            & mul_full[w-1:0])
	                  | ({w{is_mulh}}           & mul_full[2*w-1:w])
	                  | ({w{is_mulw}}           & sext32(mul_full[31:0]))
	                  | ({w{is_div}}            & div_result.full.quo)
	                  | ({w{is_rem}}            & div_result.full.rem)
	                  | ({w{is_divw}}           & sext32(div_result.word.quo))
	                  | ({w{is_remw}}           & sext32(div_result.word.rem));

	assign b_flag = (is_beq & zro) | (is_bne & ~zro)
	              | (is_blt & lt_signed) | (is_bge & ~lt_signed)
	              | (is_bltu & cry) | (is_bgeu & ~cry);

	// branch/jal from pc, jalr from rs1.
	assign pc_base = pc_src ? ops.rs1_val : pc;

	adder64 u_tgt_add (
		.op1      (pc_base),
		.op2      (imm),
		.cin      (1'b0),
		.result   (tgt_sum),
		.overflow (),
		.sign     (),
		.cout     (),
		.carry    (),
		.zero     ()
	);

	assign target_pc = {tgt_sum[w-1:1], tgt_sum[0] & ~pc_src};  // jalr clears bit 0.

endmodule

// ==== logic/adder64.sv ====
`timescale 1ns/1ns

module adder64 (
	input  logic [exe_pkg::xlen-1:0] op1,
	input  logic [exe_pkg::xlen-1:0] op2,
	input  logic                     cin,
	output logic [exe_pkg::xlen-1:0] result,
	output logic                     overflow,
	output logic                     sign,
	output logic                     cout,
	output logic                     carry,
	output logic                     zero
);

	localparam int msb = exe_pkg::xlen - 1;

	assign {cout, result} = op1 + op2 + {{msb{1'b0}}, cin};

	// same operand signs, different result sign.
	assign overflow = (op1[msb] == op2[msb]) && (result[msb] != op1[msb]);
	assign sign     = result[msb];
	assign carry    = ~cout;  // borrow after subtract.
	assign zero     = (result == '0);

endmodule

// ==== logic/operand_select.sv ====
`timescale 1ns/1ns

module operand_select (
	input  logic [exe_pkg::xlen-1:0] ex_rs1_data,
	input  logic [exe_pkg::xlen-1:0] ex_rs2_data,
	input  logic [exe_pkg::xlen-1:0] me_alu_result,
	input  logic [exe_pkg::xlen-1:0] wb_rd_data,
	input  logic [exe_pkg::xlen-1:0] pc,
	input  logic [exe_pkg::xlen-1:0] imm,
	input  logic [1:0]               rs1_src,
	input  logic [1:0]               rs2_src,
	input  logic                     alu_op1_src,
	input  logic [1:0]               alu_op2_src,
	operand_bus_if.source            ops
);

	// hazard resolution.
	always_comb begin
		case (rs1_src)
			exe_pkg::fwd_mem: ops.rs1_val = me_alu_result;
			exe_pkg::fwd_wb:  ops.rs1_val = wb_rd_data;
			default:          ops.rs1_val = ex_rs1_data;
		endcase
	end

	always_comb begin
		case (rs2_src)
			exe_pkg::fwd_mem: ops.rs2_val = me_alu_result;
			exe_pkg::fwd_wb:  ops.rs2_val = wb_rd_data;
			default:          ops.rs2_val = ex_rs2_data;
		endcase
	end

	assign ops.op1 = (alu_op1_src == exe_pkg::op1_pc) ? pc : ops.rs1_val;

	always_comb begin
		case (alu_op2_src)
			exe_pkg::op2_imm:  ops.op2 = imm;
			exe_pkg::op2_four: ops.op2 = exe_pkg::xlen'(4);  // pc + 4 for jal/jalr.
			default:           ops.op2 = ops.rs2_val;
		endcase
	end

endmodule

// ==== logic/operand_bus_if.sv ====
`timescale 1ns/1ns

interface operand_bus_if;

	logic [exe_pkg::xlen-1:0] rs1_val;  // forwarded rs1.
	logic [exe_pkg::xlen-1:0] rs2_val;  // forwarded rs2.
	logic [exe_pkg::xlen-1:0] op1;
	logic [exe_pkg::xlen-1:0] op2;

	modport source (
		output rs1_val,
		output rs2_val,
		output op1,
		output op2
	);

	modport sink (
		input rs1_val,
		input rs2_val,
		input op1,
		input op2
	);

endinterface

// ==== logic/exe_pkg.sv ====
package exe_pkg;

	localparam int xlen     = 64;  // register width.
	localparam int alu_op_w = 5;

	// alu operation codes. 0 and 31 are no-ops.
	localparam logic [alu_op_w-1:0] alu_add  = 5'd1;
	localparam logic [alu_op_w-1:0] alu_slt  = 5'd2;
	localparam logic [alu_op_w-1:0] alu_sltu = 5'd3;
	localparam logic [alu_op_w-1:0] alu_xor  = 5'd4;
	localparam logic [alu_op_w-1:0] alu_or   = 5'd5;
	localparam logic [alu_op_w-1:0] alu_and  = 5'd6;
	localparam logic [alu_op_w-1:0] alu_sll  = 5'd7;
	localparam logic [alu_op_w-1:0] alu_srl  = 5'd8;
	localparam logic [alu_op_w-1:0] alu_sra  = 5'd9;
	localparam logic [alu_op_w-1:0] alu_sub  = 5'd10;
	localparam logic [alu_op_w-1:0] alu_lui  = 5'd11;
	localparam logic [alu_op_w-1:0] alu_beq  = 5'd12;
	localparam logic [alu_op_w-1:0] alu_bne  = 5'd13;
	localparam logic [alu_op_w-1:0] alu_blt  = 5'd14;
	localparam logic [alu_op_w-1:0] alu_bge  = 5'd15;
	localparam logic [alu_op_w-1:0] alu_bltu = 5'd16;
	localparam logic [alu_op_w-1:0] alu_bgeu = 5'd17;
	localparam logic [alu_op_w-1:0] alu_addw = 5'd18;
	localparam logic [alu_op_w-1:0] alu_subw = 5'd19;
	localparam logic [alu_op_w-1:0] alu_sllw = 5'd20;
	localparam logic [alu_op_w-1:0] alu_srlw = 5'd21;
	localparam logic [alu_op_w-1:0] alu_sraw = 5'd22;
	localparam logic [alu_op_w-1:0] alu_mul  = 5'd23;
	localparam logic [alu_op_w-1:0] alu_mulh = 5'd24;
	localparam logic [alu_op_w-1:0] alu_mulw = 5'd25;
	localparam logic [alu_op_w-1:0] alu_div  = 5'd26;
	localparam logic [alu_op_w-1:0] alu_rem  = 5'd27;
	localparam logic [alu_op_w-1:0] alu_divw = 5'd28;
	localparam logic [alu_op_w-1:0] alu_remw = 5'd29;
	localparam logic [alu_op_w-1:0] alu_csr  = 5'd30;

	localparam logic [1:0] fwd_ex  = 2'd0;  // register file value.
	localparam logic [1:0] fwd_mem = 2'd1;  // memory stage alu result.
	localparam logic [1:0] fwd_wb  = 2'd2;  // write-back data.

	localparam logic op1_rs1 = 1'b0;
	localparam logic op1_pc  = 1'b1;

	localparam logic [1:0] op2_rs2  = 2'd0;
	localparam logic [1:0] op2_imm  = 2'd1;
	localparam logic [1:0] op2_four = 2'd2;  // link increment.

	typedef struct packed {
		logic [xlen-1:0] rem;
		logic [xlen-1:0] quo;
	} div_full_t;

	typedef struct packed {
		logic [31:0] rem_pad;  // sign of rem.
		logic [31:0] rem;
		logic [31:0] quo_pad;  // sign of quo.
		logic [31:0] quo;
	} div_word_t;

	typedef union packed {
		div_full_t full;
		div_word_t word;
	} div_result_t;

endpackage
